// ==== Makefile ====
TOP = tb_u1_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module u1_core
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
+incdir+include
hw/u1_pkg.sv
hw/wb_decoder.sv
hw/misc_regs.sv
hw/settings_bridge.sv
hw/vita_timer.sv
hw/u1_core.sv
sim/tb_u1_core.sv

// ==== hw/misc_regs.sv ====
// misc register slave, slot 0
// leds, clock generator control/status and a scratch test register
`timescale 1ns/10ps
`default_nettype none
`include "u1_consts.svh"

module misc_regs
  (
   input  wire                   wb_clk,
   input  wire                   wb_rst,
   input  wire u1_pkg::wb_req_t  req_i,
   output u1_pkg::wb_rsp_t       rsp_o,
   input  wire [2:0]             cgen_st_i,
   output logic [2:0]            leds_o,
   output logic [1:0]            cgen_ctrl_o
  );
   import u1_pkg::*;

   logic [6:0] offset;
   logic       wr_en;
   logic [2:0] reg_leds;
   logic [1:0] reg_cgen_ctrl;
   wb_data_t   reg_test;

   assign offset = req_i.adr[6:0];
   assign wr_en  = req_i.cyc & req_i.stb & req_i.we;

   //////////////////////////////
   // write side

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= `U1_CGEN_RESET;   // sync_b high, ref_sel high
         reg_test      <= '0;
      end
      else if (wr_en)
      begin
         case (offset)
            `U1_REG_LEDS      : reg_leds      <= req_i.dat[2:0];
            `U1_REG_CGEN_CTRL : reg_cgen_ctrl <= req_i.dat[1:0];
            `U1_REG_TEST      : reg_test      <= req_i.dat;
            default           : ;               // status and holes ignore writes
         endcase
      end
   end

   assign leds_o      = reg_leds;
   assign cgen_ctrl_o = reg_cgen_ctrl;

   //////////////////////////////
   // read side

   always_comb
   begin
      case (offset)
         `U1_REG_LEDS      : rsp_o.dat = wb_data_t'(reg_leds);
         `U1_REG_CGEN_CTRL : rsp_o.dat = wb_data_t'(reg_cgen_ctrl);
         `U1_REG_CGEN_ST   : rsp_o.dat = wb_data_t'(cgen_st_i);
         `U1_REG_TEST      : rsp_o.dat = reg_test;
         default           : rsp_o.dat = `U1_BAD_READ;
      endcase
   end

   assign rsp_o.ack = req_i.cyc & req_i.stb;   // zero wait

   a_ack: assert property (@(posedge wb_clk) disable iff (wb_rst)
      rsp_o.ack |-> !$isunknown(rsp_o.dat))
      else $error("misc ack with unknown read data");

endmodule

`default_nettype wire

// ==== hw/settings_bridge.sv ====
// settings bridge, slot 5
// pairs two 16-bit writes into one 32-bit settings strobe
`timescale 1ns/10ps
`default_nettype none

module settings_bridge
  (
   input  wire                   wb_clk,
   input  wire                   wb_rst,
   input  wire u1_pkg::wb_req_t  req_i,
   output u1_pkg::wb_rsp_t       rsp_o,
   output u1_pkg::set_bus_t      set_o
  );
   import u1_pkg::*;

   logic      wr_en;
   logic      wr_low;
   logic      wr_high;
   wb_data_t  low_half;
   logic      set_stb;
   set_addr_t set_addr;
   set_data_t set_data;

   assign wr_en   = req_i.cyc & req_i.stb & req_i.we;
   assign wr_low  = wr_en & ~req_i.adr[1];
   assign wr_high = wr_en & req_i.adr[1];    // completes the word

   // payload
   always_ff @(posedge wb_clk)
   begin
      if (wr_low)
         low_half <= req_i.dat;
      if (wr_high)
      begin
         set_addr <= set_addr_t'(req_i.adr[6:2]);
         set_data <= {req_i.dat, low_half};
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb <= 1'b0;
      else
         set_stb <= wr_high;
   end

   assign set_o = '{stb: set_stb, addr: set_addr, data: set_data};

   assign rsp_o.dat = '0;                      // write only
   assign rsp_o.ack = req_i.cyc & req_i.stb;

   a_strobe_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_stb |=> !set_stb)
      else $error("settings strobe held for two cycles");

endmodule

`default_nettype wire

// ==== hw/u1_core.sv ====
// control plane top, host wishbone bus to decoder and slaves
// misc registers on slot 0, settings bridge on slot 5 feeding the timer
`timescale 1ns/10ps
`default_nettype none
`include "u1_consts.svh"

module u1_core
  #(parameter int unsigned ticks_per_sec = `U1_TICKS_PER_SEC)
  (
   input  wire                   wb_clk,
   input  wire                   wb_rst,
   input  wire u1_pkg::wb_req_t  wb_req_i,
   output u1_pkg::wb_rsp_t       wb_rsp_o,
   input  wire [2:0]             cgen_st_i,
   input  wire                   pps_i,
   output logic [2:0]            leds_o,
   output logic [1:0]            cgen_ctrl_o,
   output u1_pkg::vita_time_t    vita_time_o,
   output logic                  pps_int_o
  );
   import u1_pkg::*;

   wb_req_t  misc_req, set_req;
   wb_rsp_t  misc_rsp, set_rsp;
   set_bus_t set_bus;

   //////////////////////////////
   // bus intercon

   wb_decoder u_decoder
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .m_req_i(wb_req_i), .m_rsp_o(wb_rsp_o),
      .misc_req_o(misc_req), .misc_rsp_i(misc_rsp),
      .set_req_o(set_req), .set_rsp_i(set_rsp));

   misc_regs u_misc
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(misc_req), .rsp_o(misc_rsp),
      .cgen_st_i(cgen_st_i), .leds_o(leds_o), .cgen_ctrl_o(cgen_ctrl_o));

   settings_bridge u_settings
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(set_req), .rsp_o(set_rsp), .set_o(set_bus));

   //////////////////////////////
   // vita timing

   vita_timer #(.base(`U1_SR_TIME64), .ticks_per_sec(ticks_per_sec)) u_timer
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_bus),
      .pps_i(pps_i), .vita_time_o(vita_time_o), .pps_int_o(pps_int_o));

endmodule

`default_nettype wire

// ==== hw/u1_pkg.sv ====
// vector typedefs, wishbone request/response structs
// settings bus struct and timer state enum
`include "u1_consts.svh"
`default_nettype none

package u1_pkg;

   typedef logic [`U1_DW-1:0] wb_data_t;
   typedef logic [`U1_AW-1:0] wb_addr_t;
   typedef logic [7:0]        set_addr_t;
   typedef logic [31:0]       set_data_t;
   typedef logic [63:0]       vita_time_t;   // seconds above, ticks below

   // master to slave, 32 bits
   typedef struct packed {
      wb_addr_t          adr;
      wb_data_t          dat;
      logic [`U1_SW-1:0] sel;
      logic              we;
      logic              cyc;
      logic              stb;
   } wb_req_t;

   typedef struct packed {
      wb_data_t dat;
      logic     ack;
   } wb_rsp_t;

   typedef struct packed {
      logic      stb;  // one cycle, no ready
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   typedef enum logic {t_run, t_armed} timer_state_t;

endpackage

`default_nettype wire

// ==== hw/vita_timer.sv ====
// 64-bit vita time counter, seconds and ticks
// pps synchronizer, immediate or pps-armed load from the settings bus
`timescale 1ns/10ps
`default_nettype none
`include "u1_consts.svh"

module vita_timer
  #(parameter int          base          = `U1_SR_TIME64,
    parameter int unsigned ticks_per_sec = `U1_TICKS_PER_SEC)
  (
   input  wire                    wb_clk,
   input  wire                    wb_rst,
   input  wire u1_pkg::set_bus_t  set_i,
   input  wire                    pps_i,
   output u1_pkg::vita_time_t     vita_time_o,
   output logic                   pps_int_o
  );
   import u1_pkg::*;

   localparam set_addr_t   a_secs    = set_addr_t'(base);
   localparam set_addr_t   a_ticks   = set_addr_t'(base + 1);
   localparam set_addr_t   a_load    = set_addr_t'(base + 2);
   localparam logic [31:0] tick_last = 32'(ticks_per_sec - 1);

   timer_state_t state;
   set_data_t    pend_secs;
   set_data_t    pend_ticks;
   logic         pps_meta, pps_sync, pps_del;
   logic         pps_edge;
   logic         load_now;
   logic         arm;

   assign load_now = set_i.stb & (set_i.addr == a_load) & (set_i.data != '0);
   assign arm      = set_i.stb & (set_i.addr == a_load) & (set_i.data == '0);
   assign pps_edge = pps_sync & ~pps_del;

   always_ff @(posedge wb_clk)
   begin
      if (set_i.stb && set_i.addr == a_secs)
         pend_secs <= set_i.data;
      if (set_i.stb && set_i.addr == a_ticks)
         pend_ticks <= set_i.data;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         {pps_meta, pps_sync, pps_del} <= '0;
         pps_int_o <= 1'b0;
      end
      else
      begin
         pps_meta  <= pps_i;   // async pin
         pps_sync  <= pps_meta;
         pps_del   <= pps_sync;
         pps_int_o <= pps_edge;
      end
   end

   //////////////////////////////
   // counter and load control

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         vita_time_o <= '0;
         state       <= t_run;
      end
      else if (load_now || (state == t_armed && pps_edge))
      begin
         vita_time_o <= {pend_secs, pend_ticks};
         state       <= t_run;
      end
      else
      begin
         if (arm)
            state <= t_armed;   // wait for next pps
         if (vita_time_o[31:0] == tick_last)
            vita_time_o <= {vita_time_o[63:32] + 32'd1, 32'd0};
         else
            vita_time_o[31:0] <= vita_time_o[31:0] + 32'd1;
      end
   end

   a_tick_range: assert property (@(posedge wb_clk) disable iff (wb_rst)
      vita_time_o[31:0] <= tick_last)
      else $error("ticks out of range");

endmodule

`default_nettype wire

// ==== hw/wb_decoder.sv ====
// single master wishbone decoder, sixteen slots on address bits 10..7
// unused slots ack at once with zero data
`timescale 1ns/10ps
`default_nettype none
`include "u1_consts.svh"

module wb_decoder
  (
   input  wire                   wb_clk,
   input  wire                   wb_rst,
   input  wire u1_pkg::wb_req_t  m_req_i,
   output u1_pkg::wb_rsp_t       m_rsp_o,
   output u1_pkg::wb_req_t       misc_req_o,
   input  wire u1_pkg::wb_rsp_t  misc_rsp_i,
   output u1_pkg::wb_req_t       set_req_o,
   input  wire u1_pkg::wb_rsp_t  set_rsp_i
  );
   import u1_pkg::*;

   logic [3:0] slot;
   logic       hit_misc;
   logic       hit_set;

   assign slot     = m_req_i.adr[`U1_AW-1:`U1_SLOT_LSB];
   assign hit_misc = (slot == `U1_SLOT_MISC);
   assign hit_set  = (slot == `U1_SLOT_SETTINGS);

   // request fan-out, only stb is qualified
   always_comb
   begin
      misc_req_o     = m_req_i;
      misc_req_o.stb = m_req_i.stb & hit_misc;
      set_req_o      = m_req_i;
      set_req_o.stb  = m_req_i.stb & hit_set;
   end

   // response mux
   always_comb
   begin
      if (hit_misc)
         m_rsp_o = misc_rsp_i;
      else if (hit_set)
         m_rsp_o = set_rsp_i;
      else
      begin
         m_rsp_o.dat = '0;                          // empty slot
         m_rsp_o.ack = m_req_i.cyc & m_req_i.stb;   // never hang the master
      end
   end

   a_one_slave: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $onehot0({misc_rsp_i.ack, set_rsp_i.ack}))
      else $error("more than one slave acknowledged");

   a_ack_cyc: assert property (@(posedge wb_clk) disable iff (wb_rst)
      m_rsp_o.ack |-> m_req_i.cyc)
      else $error("ack returned outside a bus cycle");

endmodule

`default_nettype wire

// ==== include/u1_consts.svh ====
// widths, bus slots, misc register offsets and reset values
// settings addresses and timer constants for the control plane
`ifndef U1_CONSTS_SVH
`define U1_CONSTS_SVH

// wishbone bus geometry
`define U1_DW             16
`define U1_AW             11
`define U1_SW             2

// slot select from byte address bits 10..7
`define U1_SLOT_LSB       7
`define U1_SLOT_MISC      4'd0
`define U1_SLOT_SETTINGS  4'd5

// misc slave byte offsets
`define U1_REG_LEDS       7'd0
`define U1_REG_CGEN_CTRL  7'd4
`define U1_REG_CGEN_ST    7'd6      // read only
`define U1_REG_TEST       7'd8

`define U1_BAD_READ       16'hBEEF  // unmapped misc offset
`define U1_CGEN_RESET     2'b11

// settings bus
`define U1_SR_TIME64      28        // 3 regs
`define U1_TICKS_PER_SEC  64000000

`endif

// ==== sim/tb_u1_core.sv ====
// testbench for the control plane core, misc registers, empty slots,
// settings bridge and vita timer loads, all applied from a step table
`timescale 1ns/10ps
`default_nettype none
`include "u1_consts.svh"

module tb_u1_core;
   import u1_pkg::*;

   localparam logic [31:0] tb_ticks = 32'd20;   // short second for simulation

   typedef enum {op_wr, op_rd, op_ctrl, op_load, op_adv, op_pps} op_t;

   typedef struct {
      op_t        kind;
      wb_addr_t   adr;
      wb_data_t   dat;   // write data, cycle count or reload flag
      wb_data_t   exp;
      vita_time_t tim;
   } step_t;

   logic        wb_clk = 1'b0;
   logic        wb_rst;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic [2:0]  cgen_st_i;
   logic        pps_i;
   logic [2:0]  leds_o;
   logic [1:0]  cgen_ctrl_o;
   vita_time_t  vita_time_o;
   logic        pps_int_o;

   int          seed = 32'h5f1b_9128;
   step_t       steps[$];
   logic        steps_ready = 1'b0;
   int unsigned cycle_cnt = 0;
   vita_time_t  last_time;
   int unsigned last_cycle;

   u1_core #(.ticks_per_sec(20)) DUT
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
      .cgen_st_i(cgen_st_i), .pps_i(pps_i), .leds_o(leds_o),
      .cgen_ctrl_o(cgen_ctrl_o), .vita_time_o(vita_time_o), .pps_int_o(pps_int_o));

   always #2 wb_clk = ~wb_clk;

   always @(posedge wb_clk)
      cycle_cnt <= cycle_cnt + 1;   // elapsed cycles between time samples

   //////////////////////////////
   // checks

   task automatic fail_run();
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_time(input string name, input vita_time_t got, input vita_time_t exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_ctrl(input logic [2:0] leds, input logic [2:0] leds_exp,
                             input logic [1:0] ctrl, input logic [1:0] ctrl_exp);
      if (leds !== leds_exp || ctrl !== ctrl_exp)
      begin
         $display("mismatch at %0t: leds_o got %h expected %h, cgen_ctrl_o got %h expected %h",
                  $time, leds, leds_exp, ctrl, ctrl_exp);
         fail_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         fail_run();
      end
   endtask

   // seconds and ticks counting with wrap into seconds
   function automatic vita_time_t advance_time(input vita_time_t t, input int unsigned n);
      vita_time_t r;
      r = t;
      for (int unsigned i = 0; i < n; i++)
      begin
         if (r[31:0] == tb_ticks - 32'd1)
            r = {r[63:32] + 32'd1, 32'd0};
         else
            r[31:0] = r[31:0] + 32'd1;
      end
      return r;
   endfunction

   //////////////////////////////
   // bus access

   task automatic to_drive_point();
      @(posedge wb_clk);
      #0.5;
   endtask

   task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
                            output wb_data_t rdat);
      int waited;
      waited = 0;
      wb_req.adr = adr;
      wb_req.dat = dat;
      wb_req.sel = 2'b11;
      wb_req.we  = we;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      @(negedge wb_clk);
      while (!wb_rsp.ack)   // hold until ack
      begin
         waited++;
         if (waited > 16)
         begin
            $display("no ack from the bus for address %h", adr);
            fail_run();
         end
         @(negedge wb_clk);
      end
      rdat = wb_rsp.dat;
      to_drive_point();
      wb_req = '0;
   endtask

   task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
      wb_data_t ignored;
      bus_cycle(1'b1, adr, dat, ignored);
   endtask

   task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
      bus_cycle(1'b0, adr, '0, dat);
   endtask

   //////////////////////////////
   // step table

   function automatic wb_addr_t slot_adr(input logic [3:0] slot, input logic [6:0] off);
      return {slot, off};
   endfunction

   function automatic wb_addr_t set_adr(input logic [4:0] reg_idx, input logic high);
      return {`U1_SLOT_SETTINGS, reg_idx, high, 1'b0};
   endfunction

   task automatic add_step(input op_t kind, input wb_addr_t adr, input wb_data_t dat,
                           input wb_data_t exp, input vita_time_t tim);
      step_t s;
      s.kind = kind;
      s.adr  = adr;
      s.dat  = dat;
      s.exp  = exp;
      s.tim  = tim;
      steps.push_back(s);
   endtask

   task automatic add_set(input logic [4:0] reg_idx, input set_data_t value);
      add_step(op_wr, set_adr(reg_idx, 1'b0), value[15:0], '0, '0);
      add_step(op_wr, set_adr(reg_idx, 1'b1), value[31:16], '0, '0);   // fires strobe
   endtask

   task automatic build_steps();
      wb_data_t  leds_v;
      wb_data_t  ctrl_v;
      wb_data_t  test_v;
      set_data_t secs_a;
      set_data_t secs_b;
      leds_v    = wb_data_t'($random(seed));
      ctrl_v    = wb_data_t'($random(seed));
      test_v    = wb_data_t'($random(seed));
      secs_a    = set_data_t'($random(seed));
      secs_b    = secs_a + 32'h100;
      cgen_st_i = 3'($random(seed));
      // reset state
      add_step(op_rd, slot_adr(`U1_SLOT_MISC, `U1_REG_CGEN_CTRL), '0, 16'd3, '0);
      add_step(op_ctrl, '0, '0, 16'h0018, '0);
      // misc registers
      add_step(op_wr, slot_adr(`U1_SLOT_MISC, `U1_REG_LEDS), leds_v, '0, '0);
      add_step(op_wr, slot_adr(`U1_SLOT_MISC, `U1_REG_CGEN_CTRL), ctrl_v, '0, '0);
      add_step(op_wr, slot_adr(`U1_SLOT_MISC, `U1_REG_TEST), test_v, '0, '0);
      add_step(op_rd, slot_adr(`U1_SLOT_MISC, `U1_REG_LEDS), '0, leds_v & 16'h0007, '0);
      add_step(op_rd, slot_adr(`U1_SLOT_MISC, `U1_REG_CGEN_CTRL), '0, ctrl_v & 16'h0003, '0);
      add_step(op_rd, slot_adr(`U1_SLOT_MISC, `U1_REG_TEST), '0, test_v, '0);
      add_step(op_ctrl, '0, '0, wb_data_t'({ctrl_v[1:0], leds_v[2:0]}), '0);
      add_step(op_rd, slot_adr(`U1_SLOT_MISC, `U1_REG_CGEN_ST), '0, wb_data_t'(cgen_st_i), '0);
      add_step(op_rd, slot_adr(`U1_SLOT_MISC, 7'd2), '0, `U1_BAD_READ, '0);
      // empty slot 9 acks with zero and stores nothing
      add_step(op_rd, slot_adr(4'd9, 7'd0), '0, '0, '0);
      add_step(op_wr, slot_adr(4'd9, `U1_REG_LEDS), ~leds_v, '0, '0);
      add_step(op_wr, slot_adr(4'd9, `U1_REG_CGEN_CTRL), ~ctrl_v, '0, '0);
      add_step(op_wr, slot_adr(4'd9, `U1_REG_TEST), ~test_v, '0, '0);
      add_step(op_rd, slot_adr(`U1_SLOT_MISC, `U1_REG_TEST), '0, test_v, '0);
      add_step(op_ctrl, '0, '0, wb_data_t'({ctrl_v[1:0], leds_v[2:0]}), '0);
      // immediate timer load, then free run with tick wrap
      add_set(5'(`U1_SR_TIME64), secs_a);
      add_set(5'(`U1_SR_TIME64 + 1), 32'd15);
      add_set(5'(`U1_SR_TIME64 + 2), 32'd1);
      add_step(op_load, '0, '0, '0, {secs_a, 32'd15});
      add_step(op_adv, '0, 16'd3, '0, '0);
      add_step(op_adv, '0, 16'd7, '0, '0);
      add_step(op_adv, '0, 16'd25, '0, '0);
      // armed load on the next pps only
      add_set(5'(`U1_SR_TIME64), secs_b);
      add_set(5'(`U1_SR_TIME64 + 1), 32'd2);
      add_set(5'(`U1_SR_TIME64 + 2), 32'd0);
      add_step(op_adv, '0, 16'd6, '0, '0);
      add_step(op_pps, '0, 16'd1, '0, {secs_b, 32'd2});
      add_step(op_adv, '0, 16'd4, '0, '0);
      add_step(op_pps, '0, 16'd0, '0, '0);   // no reload this time
      add_step(op_adv, '0, 16'd5, '0, '0);
   endtask

   task automatic run_step(input step_t s);
      wb_data_t   rdat;
      vita_time_t got;
      vita_time_t exp;
      int         waited;
      case (s.kind)
         op_wr : wb_write(s.adr, s.dat);
         op_rd :
         begin
            wb_read(s.adr, rdat);
            check_data("wb_rsp_o.dat", rdat, s.exp);
         end
         op_ctrl :
         begin
            @(negedge wb_clk);
            check_ctrl(leds_o, s.exp[2:0], cgen_ctrl_o, s.exp[4:3]);
            to_drive_point();
         end
         op_load :
         begin
            @(posedge wb_clk);   // edge that ends the strobe
            @(negedge wb_clk);
            got = vita_time_o;
            check_time("vita_time_o", got, s.tim);
            last_time  = got;
            last_cycle = cycle_cnt;
            to_drive_point();
         end
         op_adv :
         begin
            repeat (s.dat) @(posedge wb_clk);
            @(negedge wb_clk);
            got = vita_time_o;
            check_time("vita_time_o", got, advance_time(last_time, cycle_cnt - last_cycle));
            last_time  = got;
            last_cycle = cycle_cnt;
            to_drive_point();
         end
         op_pps :
         begin
            pps_i  = 1'b1;
            waited = 0;
            @(negedge wb_clk);
            while (!pps_int_o)
            begin
               waited++;
               if (waited > 10)
               begin
                  $display("pps_int_o never pulsed after pps_i rose");
                  fail_run();
               end
               @(negedge wb_clk);
            end
            got = vita_time_o;
            if (s.dat != '0)
               exp = s.tim;
            else
               exp = advance_time(last_time, cycle_cnt - last_cycle);
            check_time("vita_time_o", got, exp);
            last_time  = got;
            last_cycle = cycle_cnt;
            @(negedge wb_clk);
            check_flag("pps_int_o", pps_int_o, 1'b0);   // single-cycle pulse
            to_drive_point();
            pps_i = 1'b0;
            repeat (4) @(posedge wb_clk);   // let the synchronizer settle low
            #0.5;
         end
         default : ;
      endcase
   endtask

   //////////////////////////////
   // main sequence and watchdog

   initial
   begin
      wb_rst    = 1'b1;
      wb_req    = '0;
      pps_i     = 1'b0;
      cgen_st_i = '0;
      build_steps();
      steps_ready = 1'b1;
      repeat (2) @(posedge wb_clk);
      @(negedge wb_clk);
      check_time("vita_time_o", vita_time_o, '0);
      check_ctrl(leds_o, 3'd0, cgen_ctrl_o, `U1_CGEN_RESET);
      check_flag("pps_int_o", pps_int_o, 1'b0);
      to_drive_point();   // third reset edge
      wb_rst = 1'b0;
      foreach (steps[i])
         run_step(steps[i]);
      $display("No errors");
      $finish;
   end

   initial
   begin
      wait (steps_ready);
      repeat (steps.size() * 50 + 200) @(posedge wb_clk);
      $display("timeout: the step table did not finish in time");
      fail_run();
   end

endmodule

`default_nettype wire
